//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_exec_top
RTL_TOP   ?= rv_exec_top
FILELIST  ?= rv_exec_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps
PASS_MSG  ?= Simulation passed

SV_SRCS  := $(filter %.sv,$(shell cat $(FILELIST)))
RTL_SRCS := $(filter-out tb_%.sv,$(SV_SRCS))
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SV_SRCS) rv_exec_defines.svh $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) +incdir+. $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

//--- div_unit.sv
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module div_unit
  import rv_exec_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  // Dispatch strobe, always accepted
  input  logic                          valid_i,
  input  div_op_e                       op_i,
  input  word_t                         a_i,
  input  word_t                         b_i,
  input  reg_addr_t                     rd_i,
  // Result leaving the last stage
  output logic                          res_valid_o,
  output word_t                         res_o,
  output reg_addr_t                     res_rd_o,
  // Every tracker slot, for issue hazards
  output logic      [`DIVIDER_STAGES:0] pend_valid_o,
  output reg_addr_t [`DIVIDER_STAGES:0] pend_rd_o
);

  localparam int Stages = `DIVIDER_STAGES;
  localparam int Steps  = `XLEN / `DIVIDER_STAGES;

  // Slot 0 is the operand register, slot g+1 follows stage g
  logic      [Stages:0] trk_valid_q;
  reg_addr_t [Stages:0] trk_rd_q;
  logic      [Stages:0] trk_neg_a_q;
  logic      [Stages:0] trk_neg_b_q;
  div_op_e              trk_op_q [Stages+1];
  word_t                quo_q [Stages+1];
  word_t                rem_q [Stages+1];
  word_t                dsr_q [Stages+1];
  word_t                quo_d [Stages];
  word_t                rem_d [Stages];
  logic                 is_signed;
  logic                 neg_quo;

  // Steps restoring steps, quotient bits shift in where dividend bits leave
  function automatic logic [2*`XLEN-1:0] div_steps(input word_t rem, input word_t quo,
                                                   input word_t dsr);
    logic [`XLEN:0] trial;
    for (int s = 0; s < Steps; s++) begin
      trial = {rem, quo[`XLEN-1]} - {1'b0, dsr};
      if (trial[`XLEN]) begin
        // Borrow, restore
        rem = {rem[`XLEN-2:0], quo[`XLEN-1]};
        quo = {quo[`XLEN-2:0], 1'b0};
      end else begin
        rem = trial[`XLEN-1:0];
        quo = {quo[`XLEN-2:0], 1'b1};
      end
    end
    return {rem, quo};
  endfunction

  for (genvar g = 0; g < Stages; g++) begin : gen_stage
    assign {rem_d[g], quo_d[g]} = div_steps(rem_q[g], quo_q[g], dsr_q[g]);
  end

  assign is_signed = (op_i == DIV_S) || (op_i == REM_S);

  // Tracker valid bits move with the data
  always_ff @(posedge clk) begin
    if (rst) begin
      trk_valid_q <= '0;
    end else begin
      trk_valid_q <= {trk_valid_q[Stages-1:0], valid_i};
    end
  end

  always_ff @(posedge clk) begin
    // Operand register takes magnitudes for signed ops
    if (valid_i) begin
      quo_q[0]       <= (is_signed && a_i[`XLEN-1]) ? -a_i : a_i;
      dsr_q[0]       <= (is_signed && b_i[`XLEN-1]) ? -b_i : b_i;
      rem_q[0]       <= '0;
      trk_op_q[0]    <= op_i;
      trk_rd_q[0]    <= rd_i;
      trk_neg_a_q[0] <= is_signed && a_i[`XLEN-1];
      trk_neg_b_q[0] <= is_signed && b_i[`XLEN-1];
    end
    for (int i = 0; i < Stages; i++) begin
      quo_q[i+1]       <= quo_d[i];
      rem_q[i+1]       <= rem_d[i];
      dsr_q[i+1]       <= dsr_q[i];
      trk_op_q[i+1]    <= trk_op_q[i];
      trk_rd_q[i+1]    <= trk_rd_q[i];
      trk_neg_a_q[i+1] <= trk_neg_a_q[i];
      trk_neg_b_q[i+1] <= trk_neg_b_q[i];
    end
  end

  // Sign fix-up, divide by zero keeps the all-ones quotient
  assign neg_quo = (trk_neg_a_q[Stages] ^ trk_neg_b_q[Stages]) && (dsr_q[Stages] != '0);

  always_comb begin
    case (trk_op_q[Stages])
      DIV_S:   res_o = neg_quo ? -quo_q[Stages] : quo_q[Stages];
      DIV_U:   res_o = quo_q[Stages];
      // Remainder takes the dividend sign
      REM_S:   res_o = trk_neg_a_q[Stages] ? -rem_q[Stages] : rem_q[Stages];
      default: res_o = rem_q[Stages];
    endcase
  end

  assign res_valid_o  = trk_valid_q[Stages];
  assign res_rd_o     = trk_rd_q[Stages];
  assign pend_valid_o = trk_valid_q;
  assign pend_rd_o    = trk_rd_q;

endmodule

//--- int_alu.sv
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module int_alu
  import rv_exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  // Dispatch strobe, always accepted
  input  logic      valid_i,
  input  alu_op_e   op_i,
  input  word_t     a_i,
  input  word_t     b_i,
  input  reg_addr_t rd_i,
  // Registered result
  output logic      res_valid_o,
  output word_t     res_o,
  output reg_addr_t res_rd_o
);

  word_t      result;
  logic [4:0] shamt;

  // Shift amount from low 5 bits only
  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD:    result = a_i + b_i;
      ALU_SUB:    result = a_i - b_i;
      ALU_SLL:    result = a_i << shamt;
      ALU_SLT:    result = {{(`XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, a_i < b_i};
      ALU_XOR:    result = a_i ^ b_i;
      ALU_SRL:    result = a_i >> shamt;
      // Sign bit replicated
      ALU_SRA:    result = word_t'($signed(a_i) >>> shamt);
      ALU_OR:     result = a_i | b_i;
      ALU_AND:    result = a_i & b_i;
      ALU_PASS_B: result = b_i;
      default:    result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      res_o    <= result;
      res_rd_o <= rd_i;
    end
  end

endmodule

//--- issue_ctrl.sv
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module issue_ctrl
  import rv_exec_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  // Four-phase issue handshake
  input  logic                            req_i,
  input  word_t                           insn_i,
  output logic                            ack_o,
  // Register file read
  output reg_addr_t                       rs1_o,
  output reg_addr_t                       rs2_o,
  input  word_t                           rs1_data_i,
  input  word_t                           rs2_data_i,
  // ALU dispatch
  output logic                            alu_valid_o,
  output alu_op_e                         alu_op_o,
  output word_t                           alu_a_o,
  output word_t                           alu_b_o,
  output reg_addr_t                       alu_rd_o,
  // Divider dispatch
  output logic                            div_valid_o,
  output div_op_e                         div_op_o,
  output word_t                           div_a_o,
  output word_t                           div_b_o,
  output reg_addr_t                       div_rd_o,
  // Divider tracker slots
  input  logic      [`DIVIDER_STAGES:0]   pend_valid_i,
  input  reg_addr_t [`DIVIDER_STAGES:0]   pend_rd_i
);

  opcode_e      opcode;
  logic [2:0]   funct3;
  logic [6:0]   funct7;
  reg_addr_t    rd;
  word_t        imm_i;
  word_t        imm_u;
  logic         alt_op;
  logic         is_alu;
  logic         is_div;
  logic         uses_rs1;
  logic         uses_rs2;
  alu_op_e      dec_alu_op;
  word_t        op_b;
  issue_state_e state_q;
  logic         rec_valid_q;
  reg_addr_t    rec_rd_q;
  // Index 0 is the divide just dispatched, index j is tracker slot j-1
  logic      [`DIVIDER_STAGES+1:0] slot_valid;
  reg_addr_t [`DIVIDER_STAGES+1:0] slot_rd;
  logic         raw_hazard;
  logic         waw_hazard;
  logic         wb_collision;
  logic         accept;

  // Field extraction
  assign opcode = opcode_e'(insn_i[6:0]);
  assign rd     = insn_i[11:7];
  assign funct3 = insn_i[14:12];
  assign rs1_o  = insn_i[19:15];
  assign rs2_o  = insn_i[24:20];
  assign funct7 = insn_i[31:25];
  assign imm_i  = {{(`XLEN-12){insn_i[31]}}, insn_i[31:20]};
  assign imm_u  = {insn_i[31:12], 12'b0};
  // SUB and SRA/SRAI, bit 30 is not a sub select in ADDI
  assign alt_op = funct7[5] && (opcode == OPC_OP || funct3 == 3'b101);

  always_comb begin
    is_alu = 1'b0;
    is_div = 1'b0;
    op_b   = rs2_data_i;
    case (funct3)
      3'b000:  dec_alu_op = alt_op ? ALU_SUB : ALU_ADD;
      3'b001:  dec_alu_op = ALU_SLL;
      3'b010:  dec_alu_op = ALU_SLT;
      3'b011:  dec_alu_op = ALU_SLTU;
      3'b100:  dec_alu_op = ALU_XOR;
      3'b101:  dec_alu_op = alt_op ? ALU_SRA : ALU_SRL;
      3'b110:  dec_alu_op = ALU_OR;
      default: dec_alu_op = ALU_AND;
    endcase
    case (opcode)
      OPC_OP_IMM: begin
        is_alu = 1'b1;
        op_b   = imm_i;
      end
      OPC_OP: begin
        // MUL group is not supported here
        is_div = (funct7 == 7'b0000001) && funct3[2];
        is_alu = (funct7 == 7'b0000000) ||
                 (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      OPC_LUI: begin
        is_alu     = 1'b1;
        op_b       = imm_u;
        dec_alu_op = ALU_PASS_B;
      end
      default: ;
    endcase
  end

  // LUI has no sources, OP-IMM only rs1
  assign uses_rs1 = (is_alu || is_div) && opcode != OPC_LUI;
  assign uses_rs2 = is_div || (is_alu && opcode == OPC_OP);

  assign slot_valid = {pend_valid_i, div_valid_o};
  assign slot_rd    = {pend_rd_i, div_rd_o};

  // Hazards against results not yet in the register file
  always_comb begin
    raw_hazard = 1'b0;
    waw_hazard = 1'b0;
    if (rec_valid_q && rec_rd_q != '0) begin
      raw_hazard |= (uses_rs1 && rs1_o == rec_rd_q) || (uses_rs2 && rs2_o == rec_rd_q);
    end
    for (int i = 0; i < `DIVIDER_STAGES + 2; i++) begin
      if (slot_valid[i] && slot_rd[i] != '0) begin
        raw_hazard |= (uses_rs1 && rs1_o == slot_rd[i]) || (uses_rs2 && rs2_o == slot_rd[i]);
        // Keep same-rd writebacks in issue order
        waw_hazard |= (is_alu || is_div) && rd == slot_rd[i];
      end
    end
  end

  // Divide two slots short of the output would share the ALU writeback cycle
  assign wb_collision = is_alu && slot_valid[`DIVIDER_STAGES-1];

  assign accept = (state_q == ISS_IDLE) && req_i &&
                  !(raw_hazard || waw_hazard || wb_collision);
  assign ack_o  = (state_q == ISS_ACK);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= ISS_IDLE;
      alu_valid_o <= 1'b0;
      div_valid_o <= 1'b0;
      rec_valid_q <= 1'b0;
    end else begin
      alu_valid_o <= accept && is_alu;
      div_valid_o <= accept && is_div;
      // ALU op now inside int_alu
      rec_valid_q <= alu_valid_o;
      case (state_q)
        ISS_IDLE: if (accept) state_q <= ISS_ACK;
        default:  if (!req_i) state_q <= ISS_IDLE;
      endcase
    end
  end

  // Dispatch payload
  always_ff @(posedge clk) begin
    rec_rd_q <= alu_rd_o;
    if (accept) begin
      alu_op_o <= dec_alu_op;
      alu_a_o  <= rs1_data_i;
      alu_b_o  <= op_b;
      alu_rd_o <= rd;
      div_op_o <= div_op_e'(funct3[1:0]);
      div_a_o  <= rs1_data_i;
      div_b_o  <= rs2_data_i;
      div_rd_o <= rd;
    end
  end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module reg_file
  import rv_exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  // Read ports
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o,
  // Write port from writeback
  input  logic      we_i,
  input  reg_addr_t wd_rd_i,
  input  word_t     wd_data_i
);

  word_t regs_q [`NUM_REGS];

  // x0 never written, stays zero from reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && wd_rd_i != '0) begin
      regs_q[wd_rd_i] <= wd_data_i;
    end
  end

  // x0 reads zero, then write-through of a same-cycle write
  assign rs1_data_o = (rs1_i == '0) ? '0 :
                      (we_i && wd_rd_i == rs1_i) ? wd_data_i : regs_q[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 :
                      (we_i && wd_rd_i == rs2_i) ? wd_data_i : regs_q[rs2_i];

endmodule

//--- rv_exec_defines.svh
`ifndef RV_EXEC_DEFINES_SVH
`define RV_EXEC_DEFINES_SVH

// Data path width
`define XLEN 32

// Register index width and register count
`define REG_ADDR_W 5
`define NUM_REGS 32

// Major opcode field width
`define OPCODE_W 7

// Depth of the unsigned divide pipeline
// Must divide 32, each stage retires 32/DIVIDER_STAGES quotient bits
`define DIVIDER_STAGES 8

`endif

//--- rv_exec_pkg.sv
`include "rv_exec_defines.svh"

package rv_exec_pkg;

  // Data word and register index
  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // Major opcodes kept in this cluster
  typedef enum logic [`OPCODE_W-1:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // LUI result, operand b unchanged
    ALU_PASS_B
  } alu_op_e;

  // Encoded as funct3[1:0] of the M-extension divides
  typedef enum logic [1:0] {
    DIV_S = 2'b00,
    DIV_U = 2'b01,
    REM_S = 2'b10,
    REM_U = 2'b11
  } div_op_e;

  // Issue handshake state
  typedef enum logic {
    ISS_IDLE,
    ISS_ACK
  } issue_state_e;

endpackage

//--- rv_exec_top.f
+incdir+.
rv_exec_pkg.sv
reg_file.sv
issue_ctrl.sv
int_alu.sv
div_unit.sv
wb_merge.sv
rv_exec_top.sv
tb_rv_exec_top.sv

//--- rv_exec_top.sv
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module rv_exec_top
  import rv_exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  // Instruction issue
  input  logic      req_i,
  input  word_t     insn_i,
  output logic      ack_o,
  // Writeback trace
  output logic      wb_valid_o,
  output reg_addr_t wb_rd_o,
  output word_t     wb_data_o
);

  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rs1_data;
  word_t     rs2_data;
  // Dispatch to ALU
  logic      alu_valid;
  alu_op_e   alu_op;
  word_t     alu_a;
  word_t     alu_b;
  reg_addr_t alu_rd;
  // Dispatch to divider
  logic      div_valid;
  div_op_e   div_op;
  word_t     div_a;
  word_t     div_b;
  reg_addr_t div_rd;
  logic      [`DIVIDER_STAGES:0] pend_valid;
  reg_addr_t [`DIVIDER_STAGES:0] pend_rd;
  // Unit results
  logic      alu_res_valid;
  word_t     alu_res;
  reg_addr_t alu_res_rd;
  logic      div_res_valid;
  word_t     div_res;
  reg_addr_t div_res_rd;

  // Writeback also drives the write port
  reg_file u_reg_file (
    .clk(clk), .rst(rst),
    .rs1_i(rs1), .rs2_i(rs2), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .we_i(wb_valid_o), .wd_rd_i(wb_rd_o), .wd_data_i(wb_data_o)
  );

  issue_ctrl u_issue_ctrl (
    .clk(clk), .rst(rst), .req_i(req_i), .insn_i(insn_i), .ack_o(ack_o),
    .rs1_o(rs1), .rs2_o(rs2), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .alu_valid_o(alu_valid), .alu_op_o(alu_op), .alu_a_o(alu_a), .alu_b_o(alu_b),
    .alu_rd_o(alu_rd),
    .div_valid_o(div_valid), .div_op_o(div_op), .div_a_o(div_a), .div_b_o(div_b),
    .div_rd_o(div_rd),
    .pend_valid_i(pend_valid), .pend_rd_i(pend_rd)
  );

  int_alu u_int_alu (
    .clk(clk), .rst(rst),
    .valid_i(alu_valid), .op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .rd_i(alu_rd),
    .res_valid_o(alu_res_valid), .res_o(alu_res), .res_rd_o(alu_res_rd)
  );

  div_unit u_div_unit (
    .clk(clk), .rst(rst),
    .valid_i(div_valid), .op_i(div_op), .a_i(div_a), .b_i(div_b), .rd_i(div_rd),
    .res_valid_o(div_res_valid), .res_o(div_res), .res_rd_o(div_res_rd),
    .pend_valid_o(pend_valid), .pend_rd_o(pend_rd)
  );

  wb_merge u_wb_merge (
    .clk(clk), .rst(rst),
    .alu_valid_i(alu_res_valid), .alu_res_i(alu_res), .alu_rd_i(alu_res_rd),
    .div_valid_i(div_res_valid), .div_res_i(div_res), .div_rd_i(div_res_rd),
    .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
  );

endmodule

//--- tb_rv_exec_top.sv
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module tb_rv_exec_top
  import rv_exec_pkg::*;
();

  localparam int n_insns         = 400;
  localparam int reset_cycles    = 10;
  localparam int alu_latency     = 2;
  localparam int div_latency     = `DIVIDER_STAGES + 2;
  localparam int watchdog_cycles = reset_cycles + n_insns * (`DIVIDER_STAGES + 12);

  // One expected writeback, kept in issue order
  typedef struct packed {
    reg_addr_t   rd;
    word_t       data;
    logic [31:0] due;
  } expect_t;

  logic        clk;
  logic        rst;
  logic        req;
  word_t       insn;
  logic        ack;
  logic        wb_valid;
  reg_addr_t   wb_rd;
  word_t       wb_data;
  // Architectural state of the reference model
  word_t       regs_model [`NUM_REGS] = '{default: '0};
  expect_t     exp_q [$];
  word_t       rng_state = 32'd39;
  logic [31:0] cyc = '0;
  logic        ack_prev = 1'b0;
  logic        req_prev = 1'b0;
  int          issued = 0;

  rv_exec_top dut0 (
    .clk(clk), .rst(rst), .req_i(req), .insn_i(insn), .ack_o(ack),
    .wb_valid_o(wb_valid), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Rising edges seen so far
  always @(posedge clk) cyc <= cyc + 32'd1;

  function automatic word_t xorshift32(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t got, input word_t want);
    if (got !== want) begin
      abort_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want));
    end
  endtask

  // RV32I integer result, alt picks SUB or SRA
  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // RV32M divide and remainder, zero divisor and overflow per the spec
  function automatic word_t div_ref(input logic [1:0] kind, input word_t a, input word_t b);
    logic  ovf;
    word_t q;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (kind)
      2'b00: q = (b == '0) ? 32'hffff_ffff :
                 ovf ? 32'h8000_0000 : word_t'($signed(a) / $signed(b));
      2'b01: q = (b == '0) ? 32'hffff_ffff : a / b;
      2'b10: q = (b == '0) ? a : ovf ? 32'h0 : word_t'($signed(a) % $signed(b));
      default: q = (b == '0) ? a : a % b;
    endcase
    return q;
  endfunction

  // Evaluate at acceptance, stalls keep operands current
  task automatic model_accept(input word_t ins, input logic [31:0] acc_cyc);
    logic [2:0] f3;
    logic [6:0] f7;
    reg_addr_t  rd;
    word_t      a;
    word_t      b;
    word_t      res;
    logic       writes;
    logic       is_div;
    expect_t    e;
    f3     = ins[14:12];
    f7     = ins[31:25];
    rd     = ins[11:7];
    a      = regs_model[ins[19:15]];
    b      = regs_model[ins[24:20]];
    res    = '0;
    writes = 1'b1;
    is_div = 1'b0;
    case (ins[6:0])
      7'b0010011: res = alu_ref(f3, f3 == 3'b101 && ins[30], a, {{20{ins[31]}}, ins[31:20]});
      7'b0110011: begin
        if (f7 == 7'b0000001 && f3[2]) begin
          res    = div_ref(f3[1:0], a, b);
          is_div = 1'b1;
        end else if (f7 == 7'b0000000 ||
                     (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101))) begin
          res = alu_ref(f3, f7[5], a, b);
        end else begin
          // MUL group and other funct7 values
          writes = 1'b0;
        end
      end
      7'b0110111: res = {ins[31:12], 12'b0};
      default:    writes = 1'b0;
    endcase
    if (writes && rd != '0) begin
      regs_model[rd] = res;
      e.rd   = rd;
      e.data = res;
      e.due  = acc_cyc + 32'(is_div ? div_latency : alu_latency);
      exp_q.push_back(e);
    end
  endtask

  // Oldest pending entry for this rd
  task automatic retire_writeback(input reg_addr_t rd, input word_t data, input logic [31:0] at);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (idx < 0 && exp_q[i].rd == rd) idx = i;
    end
    if (rd == '0) begin
      abort_run("A writeback to x0 appeared on the trace port");
    end else if (idx < 0) begin
      abort_run($sformatf("A writeback to x%0d arrived with no instruction waiting for it", rd));
    end else begin
      check_value("wb_data_o", data, exp_q[idx].data);
      check_value("wb_cycle", at, exp_q[idx].due);
      exp_q.delete(idx);
    end
  endtask

  // Sampled mid-cycle, away from both edges
  always @(negedge clk) begin
    if (!rst) begin
      if (wb_valid) retire_writeback(wb_rd, wb_data, cyc);
      if (ack && !ack_prev) begin
        if (!req_prev) abort_run("ack_o rose while req_i was low");
        else model_accept(insn, cyc);
      end
      for (int i = 0; i < exp_q.size(); i++) begin
        if (exp_q[i].due <= cyc) begin
          abort_run($sformatf("Writeback to x%0d due at cycle %0d never arrived",
                              exp_q[i].rd, exp_q[i].due));
        end
      end
    end
    ack_prev <= ack;
    req_prev <= req;
  end

  // Full four-phase cycle, entered and left 1 ns after an edge
  task automatic issue_insn(input word_t ins);
    insn = ins;
    req  = 1'b1;
    @(posedge clk);
    #1;
    while (!ack) begin
      @(posedge clk);
      #1;
    end
    req = 1'b0;
    while (ack) begin
      @(posedge clk);
      #1;
    end
    issued++;
  endtask

  task automatic gen_and_issue();
    word_t      r;
    word_t      s;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  ra;
    reg_addr_t  rb;
    logic [2:0] f3;
    logic [11:0] imm;
    r   = next_rand();
    s   = next_rand();
    // x0..x7 only, dependences stay frequent
    rd  = {2'b0, s[2:0]};
    rs1 = {2'b0, s[5:3]};
    rs2 = {2'b0, s[8:6]};
    f3  = s[11:9];
    imm = s[23:12];
    if (r[3:0] < 4'd5) begin
      // Shift immediates hold shamt, SRAI sets bit 30
      if (f3 == 3'b001) imm = {7'b0, s[16:12]};
      else if (f3 == 3'b101) imm = {1'b0, r[4], 5'b0, s[16:12]};
      issue_insn({imm, rs1, f3, rd, OPC_OP_IMM});
    end else if (r[3:0] < 4'd10) begin
      issue_insn({1'b0, r[4] && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd, OPC_OP});
    end else if (r[3:0] == 4'd10) begin
      issue_insn({s[31:12], rd, OPC_LUI});
    end else if (r[3:0] < 4'd14) begin
      // Divisor from x0 now and then
      if (r[6:4] == 3'd0) rs2 = '0;
      issue_insn({7'b0000001, rs2, rs1, 1'b1, f3[1:0], rd, OPC_OP});
    end else if (r[3:0] == 4'd14) begin
      // 0x80000000 over -1
      ra = {3'b0, r[5:4]} + 5'd1;
      rb = {4'b0, r[6]} + 5'd5;
      issue_insn({20'h80000, ra, OPC_LUI});
      issue_insn({12'hfff, 5'd0, 3'b000, rb, OPC_OP_IMM});
      issue_insn({7'b0000001, rb, ra, 1'b1, f3[1:0], rd, OPC_OP});
    end else if (r[4]) begin
      // MUL group, accepted without writeback
      issue_insn({7'b0000001, rs2, rs1, 1'b0, f3[1:0], rd, OPC_OP});
    end else begin
      // Load opcode, not handled here
      issue_insn({s[31:12], rd, 7'b0000011});
    end
  endtask

  initial begin
    rst  = 1'b1;
    req  = 1'b0;
    insn = '0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    while (issued < n_insns) begin
      gen_and_issue();
      // Idle edges with req_i low between instructions
      repeat (next_rand() % 4) begin
        @(posedge clk);
        #1;
      end
    end
    // Last divide writes back within div_latency cycles of acceptance
    repeat (div_latency + 2) @(posedge clk);
    if (exp_q.size() != 0) begin
      abort_run("Expected writebacks were still pending at the end of the run");
    end else begin
      $display("%0d instructions issued", issued);
      $display("Simulation passed");
      $finish;
    end
  end

  // Watchdog
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    abort_run($sformatf("Run did not finish within %0d cycles", watchdog_cycles));
  end

endmodule

//--- wb_merge.sv
`timescale 1ns/1ps

module wb_merge
  import rv_exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  // ALU result
  input  logic      alu_valid_i,
  input  word_t     alu_res_i,
  input  reg_addr_t alu_rd_i,
  // Divider result
  input  logic      div_valid_i,
  input  word_t     div_res_i,
  input  reg_addr_t div_rd_i,
  // Register file write and trace
  output logic      wb_valid_o,
  output reg_addr_t wb_rd_o,
  output word_t     wb_data_o
);

  logic alu_wr;
  logic div_wr;

  // x0 destinations produce no writeback
  assign alu_wr = alu_valid_i && alu_rd_i != '0;
  assign div_wr = div_valid_i && div_rd_i != '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= alu_wr || div_wr;
    end
  end

  // Issue stalls keep the two units from completing together
  always_ff @(posedge clk) begin
    if (alu_wr) begin
      wb_rd_o   <= alu_rd_i;
      wb_data_o <= alu_res_i;
    end else if (div_wr) begin
      wb_rd_o   <= div_rd_i;
      wb_data_o <= div_res_i;
    end
  end

endmodule
